//--- logic/adc_capture.sv
////////////////////////////////////////////////////////////
// adc capture: registers both channels, muxes in the test
// ramp and produces the decimated sample strobe
////////////////////////////////////////////////////////////

module adc_capture (
    input  logic                        clk_29_7_1M,
    input  logic                        i_reset,
    input  adc_pkg::sample_t            i_adc_a,
    input  adc_pkg::sample_t            i_adc_b,
    input  logic                        i_enable,
    input  logic                        i_test_src,
    input  logic [adc_pkg::DECIM_W-1:0] i_decim,
    input  logic                        i_mode_update,
    output logic                        o_smp_valid,
    output adc_pkg::sample_t            o_ch_a,
    output adc_pkg::sample_t            o_ch_b
);
    import adc_pkg::*;

    sample_t            adc_a_q;
    sample_t            adc_b_q;
    sample_t            ramp_q;
    logic [DECIM_W-1:0] decim_cnt;
    logic [DECIM_W-1:0] decim_eff;
    logic               strobe;

    // converter outputs sampled every edge
    always_ff @(posedge clk_29_7_1M) begin
        adc_a_q <= i_adc_a;
        adc_b_q <= i_adc_b;
    end

    assign decim_eff = (i_decim < DECIM_MIN) ? DECIM_MIN : i_decim;    // 0 acts as 1
    assign strobe    = i_enable && !i_mode_update && (decim_cnt >= decim_eff - 1'b1);

    always_ff @(posedge clk_29_7_1M) begin
        if (i_reset) begin
            decim_cnt   <= '0;
            ramp_q      <= RAMP_INIT;
            o_smp_valid <= 1'b0;
        end else begin
            o_smp_valid <= strobe;
            if (i_mode_update) begin
                decim_cnt <= '0;
                ramp_q    <= RAMP_INIT;    // ramp restarts per mode
            end else begin
                if (strobe) begin
                    decim_cnt <= '0;
                end else if (i_enable) begin
                    decim_cnt <= decim_cnt + 1'b1;
                end
                if (strobe && i_test_src) begin
                    ramp_q <= ramp_q + RAMP_STEP;
                end
            end
        end
    end

    // sample pair, held between strobes
    always_ff @(posedge clk_29_7_1M) begin
        if (strobe) begin
            o_ch_a <= i_test_src ? ramp_q : adc_a_q;
            o_ch_b <= i_test_src ? ~ramp_q : adc_b_q;    // complement in test mode
        end
    end

endmodule

//--- logic/adc_fiber_top.sv
////////////////////////////////////////////////////////////
// adc to fiber top: capture, packing, lane buffering and
// the two four-phase links to the transceiver
////////////////////////////////////////////////////////////

module adc_fiber_top (
    input  logic                 clk_29_7_1M,
    input  logic                 i_reset,
    input  adc_pkg::sample_t     i_adc_a,
    input  adc_pkg::sample_t     i_adc_b,
    output logic                 o_tx_req,
    output link_pkg::lane_word_t o_tx_word,
    input  logic                 i_tx_ack,
    input  logic                 i_rx_req,
    input  link_pkg::lane_word_t i_rx_word,
    output logic                 o_rx_ack,
    output logic                 o_overflow
);
    import adc_pkg::*;
    import link_pkg::*;

    // mode from the remote end
    logic               enable;
    logic               test_src;
    logic [DECIM_W-1:0] decim;
    logic               mode_update;

    logic               smp_valid;
    sample_t            ch_a;
    sample_t            ch_b;
    logic               wr_en;
    lane_word_t         wr_word;
    lane_word_t         head;
    logic               not_empty;
    logic               pop;

    ctrl_rx u_ctrl_rx (
        .clk_29_7_1M   (clk_29_7_1M),
        .i_reset       (i_reset),
        .i_rx_req      (i_rx_req),
        .i_rx_word     (i_rx_word),
        .o_rx_ack      (o_rx_ack),
        .o_enable      (enable),
        .o_test_src    (test_src),
        .o_decim       (decim),
        .o_mode_update (mode_update)
    );

    adc_capture u_adc_capture (
        .clk_29_7_1M   (clk_29_7_1M),
        .i_reset       (i_reset),
        .i_adc_a       (i_adc_a),
        .i_adc_b       (i_adc_b),
        .i_enable      (enable),
        .i_test_src    (test_src),
        .i_decim       (decim),
        .i_mode_update (mode_update),
        .o_smp_valid   (smp_valid),
        .o_ch_a        (ch_a),
        .o_ch_b        (ch_b)
    );

    sample_packer u_sample_packer (
        .clk_29_7_1M   (clk_29_7_1M),
        .i_reset       (i_reset),
        .i_smp_valid   (smp_valid),
        .i_ch_a        (ch_a),
        .i_ch_b        (ch_b),
        .i_mode_update (mode_update),
        .o_wr_en       (wr_en),
        .o_wr_word     (wr_word)
    );

    lane_fifo u_lane_fifo (
        .clk_29_7_1M   (clk_29_7_1M),
        .i_reset       (i_reset),
        .i_wr_en       (wr_en),
        .i_wr_word     (wr_word),
        .i_pop         (pop),
        .i_mode_update (mode_update),
        .o_head        (head),
        .o_not_empty   (not_empty),
        .o_overflow    (o_overflow)
    );

    lane_tx u_lane_tx (
        .clk_29_7_1M (clk_29_7_1M),
        .i_reset     (i_reset),
        .i_head      (head),
        .i_not_empty (not_empty),
        .i_tx_ack    (i_tx_ack),
        .o_pop       (pop),
        .o_tx_req    (o_tx_req),
        .o_tx_word   (o_tx_word)
    );

endmodule

//--- logic/adc_pkg.sv
////////////////////////////////////////////////////////////
// adc side definitions: sample width, test ramp constants
// and decimation limits
////////////////////////////////////////////////////////////

package adc_pkg;

    // one converter sample
    localparam int SAMPLE_W = 12;

    typedef logic [SAMPLE_W-1:0] sample_t;

    // test ramp, restarted on every mode change
    localparam sample_t RAMP_INIT = '0;
    localparam sample_t RAMP_STEP = sample_t'(1);    // per decimated sample

    // decimation factor, a factor of 0 acts as 1
    localparam int DECIM_W = 8;

    localparam logic [DECIM_W-1:0] DECIM_MIN = DECIM_W'(1);    // also the reset factor

endpackage

//--- logic/ctrl_rx.sv
////////////////////////////////////////////////////////////
// control receiver: four-phase req/ack sink for remote
// control words, holds the streaming mode registers
////////////////////////////////////////////////////////////

module ctrl_rx (
    input  logic                        clk_29_7_1M,
    input  logic                        i_reset,
    input  logic                        i_rx_req,
    input  link_pkg::lane_word_t        i_rx_word,
    output logic                        o_rx_ack,
    output logic                        o_enable,
    output logic                        o_test_src,
    output logic [adc_pkg::DECIM_W-1:0] o_decim,
    output logic                        o_mode_update
);
    import adc_pkg::*;
    import link_pkg::*;

    logic take;
    logic set_mode;

    assign take     = i_rx_req && !o_rx_ack;    // new word offered
    assign set_mode = (i_rx_word.ctrl.kind == KIND_CTRL)
                   && (i_rx_word.ctrl.opcode == OP_SET_MODE);

    always_ff @(posedge clk_29_7_1M) begin
        if (i_reset) begin
            o_rx_ack      <= 1'b0;
            o_enable      <= 1'b0;
            o_test_src    <= 1'b0;    // adc source
            o_decim       <= DECIM_MIN;
            o_mode_update <= 1'b0;
        end else begin
            o_mode_update <= take && set_mode;

            // every word is acked, whatever its kind or opcode
            if (take) begin
                o_rx_ack <= 1'b1;
            end else if (o_rx_ack && !i_rx_req) begin
                o_rx_ack <= 1'b0;
            end

            if (take && set_mode) begin
                o_enable   <= i_rx_word.ctrl.value[MODE_EN_BIT];
                o_test_src <= i_rx_word.ctrl.value[MODE_TEST_BIT];
                o_decim    <= i_rx_word.ctrl.value[MODE_DECIM_LSB +: DECIM_W];
            end
        end
    end

endmodule

//--- logic/lane_fifo.sv
////////////////////////////////////////////////////////////
// lane fifo: word buffer in front of the fiber transmitter,
// drops on full and keeps a sticky overflow flag
////////////////////////////////////////////////////////////

module lane_fifo (
    input  logic                 clk_29_7_1M,
    input  logic                 i_reset,
    input  logic                 i_wr_en,
    input  link_pkg::lane_word_t i_wr_word,
    input  logic                 i_pop,
    input  logic                 i_mode_update,
    output link_pkg::lane_word_t o_head,
    output logic                 o_not_empty,
    output logic                 o_overflow
);
    import link_pkg::*;

    lane_word_t         mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               full;
    logic               do_wr;
    logic               do_rd;

    assign full        = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign do_wr       = i_wr_en && !full;    // write on full is lost
    assign do_rd       = i_pop && o_not_empty;
    assign o_not_empty = (count != '0);
    assign o_head      = mem[rd_ptr];    // head visible the cycle after write

    always_ff @(posedge clk_29_7_1M) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr_word;
        end
    end

    always_ff @(posedge clk_29_7_1M) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;    // depth is a power of two
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // sticky until the remote end sets a new mode
    always_ff @(posedge clk_29_7_1M) begin
        if (i_reset || i_mode_update) begin
            o_overflow <= 1'b0;
        end else if (i_wr_en && full) begin
            o_overflow <= 1'b1;
        end
    end

endmodule

//--- logic/lane_tx.sv
////////////////////////////////////////////////////////////
// lane transmitter: four-phase req/ack sender toward the
// fiber transceiver
////////////////////////////////////////////////////////////

module lane_tx (
    input  logic                 clk_29_7_1M,
    input  logic                 i_reset,
    input  link_pkg::lane_word_t i_head,
    input  logic                 i_not_empty,
    input  logic                 i_tx_ack,
    output logic                 o_pop,
    output logic                 o_tx_req,
    output link_pkg::lane_word_t o_tx_word
);
    import link_pkg::*;

    logic [1:0] state_q;

    // head leaves the fifo once the far side has it
    assign o_pop = (state_q == TX_REQ) && i_tx_ack;

    always_ff @(posedge clk_29_7_1M) begin
        if (i_reset) begin
            state_q  <= TX_IDLE;
            o_tx_req <= 1'b0;
        end else begin
            case (state_q)
                TX_IDLE: begin
                    if (i_not_empty) begin
                        o_tx_req <= 1'b1;
                        state_q  <= TX_REQ;
                    end
                end
                TX_REQ: begin
                    if (i_tx_ack) begin
                        o_tx_req <= 1'b0;
                        state_q  <= TX_WAIT;
                    end
                end
                TX_WAIT: begin
                    if (!i_tx_ack) begin
                        state_q <= TX_IDLE;    // handshake closed
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    // word held stable for the whole req phase
    always_ff @(posedge clk_29_7_1M) begin
        if (state_q == TX_IDLE && i_not_empty) begin
            o_tx_word <= i_head;
        end
    end

endmodule

//--- logic/link_pkg.sv
////////////////////////////////////////////////////////////
// fiber link definitions: lane word views, opcodes, framing
// and lane FIFO sizing
////////////////////////////////////////////////////////////

package link_pkg;

    localparam int SEQ_W    = 7;
    localparam int OPCODE_W = 7;
    localparam int VALUE_W  = 24;

    localparam logic KIND_DATA = 1'b0;
    localparam logic KIND_CTRL = 1'b1;

    // sample pair view
    typedef struct packed {
        logic             kind;    // 0 for data
        logic [SEQ_W-1:0] seq;
        adc_pkg::sample_t ch_b;
        adc_pkg::sample_t ch_a;
    } lane_data_t;

    // header and control view
    typedef struct packed {
        logic                kind;    // 1 for control
        logic [OPCODE_W-1:0] opcode;
        logic [VALUE_W-1:0]  value;
    } lane_ctrl_t;

    // 32 bit word on both links, kind bit selects the view
    typedef union packed {
        lane_data_t data;
        lane_ctrl_t ctrl;
    } lane_word_t;

    localparam logic [OPCODE_W-1:0] OP_FRAME_HDR = 7'd1;    // value is the frame count
    localparam logic [OPCODE_W-1:0] OP_SET_MODE  = 7'd2;

    // SET_MODE value fields
    localparam int MODE_EN_BIT    = 0;
    localparam int MODE_TEST_BIT  = 1;
    localparam int MODE_DECIM_LSB = 8;

    localparam int FRAME_LEN   = 8;    // data words per frame
    localparam int FRAME_CNT_W = $clog2(FRAME_LEN + 1);

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    // transmitter states
    localparam logic [1:0] TX_IDLE = 2'd0;
    localparam logic [1:0] TX_REQ  = 2'd1;
    localparam logic [1:0] TX_WAIT = 2'd2;

endpackage

//--- logic/sample_packer.sv
////////////////////////////////////////////////////////////
// sample packer: turns sample pairs into sequenced data
// words and puts a frame header in front of every frame
////////////////////////////////////////////////////////////

module sample_packer (
    input  logic                 clk_29_7_1M,
    input  logic                 i_reset,
    input  logic                 i_smp_valid,
    input  adc_pkg::sample_t     i_ch_a,
    input  adc_pkg::sample_t     i_ch_b,
    input  logic                 i_mode_update,
    output logic                 o_wr_en,
    output link_pkg::lane_word_t o_wr_word
);
    import link_pkg::*;

    logic [SEQ_W-1:0]       seq_q;
    logic [VALUE_W-1:0]     frame_cnt;
    logic [FRAME_CNT_W-1:0] word_cnt;     // data words in the open frame
    logic                   need_hdr;
    lane_word_t             data_word;
    lane_word_t             hdr_word;
    lane_word_t             hold_word;    // data word waiting behind its header
    logic                   hold_valid;

    // frame full, or freshly reset by a mode change
    assign need_hdr = (word_cnt == FRAME_CNT_W'(FRAME_LEN));

    always_comb begin
        data_word           = '0;
        data_word.data.kind = KIND_DATA;
        data_word.data.seq  = seq_q;
        data_word.data.ch_b = i_ch_b;
        data_word.data.ch_a = i_ch_a;

        hdr_word             = '0;
        hdr_word.ctrl.kind   = KIND_CTRL;
        hdr_word.ctrl.opcode = OP_FRAME_HDR;
        hdr_word.ctrl.value  = frame_cnt;
    end

    always_ff @(posedge clk_29_7_1M) begin
        if (i_reset || i_mode_update) begin
            o_wr_en    <= 1'b0;
            hold_valid <= 1'b0;
            seq_q      <= '0;
            frame_cnt  <= '0;
            word_cnt   <= FRAME_CNT_W'(FRAME_LEN);    // header before first data
        end else begin
            o_wr_en <= 1'b0;
            if (hold_valid) begin
                o_wr_en    <= 1'b1;
                o_wr_word  <= hold_word;
                hold_valid <= 1'b0;
                // back to back samples keep the hold busy
                // a sample that would need a header here has no slot and is skipped
                if (i_smp_valid && !need_hdr) begin
                    hold_word  <= data_word;
                    hold_valid <= 1'b1;
                    seq_q      <= seq_q + 1'b1;
                    word_cnt   <= word_cnt + 1'b1;
                end
            end else if (i_smp_valid) begin
                o_wr_en  <= 1'b1;
                seq_q    <= seq_q + 1'b1;    // counts even if the fifo drops it
                if (need_hdr) begin
                    o_wr_word  <= hdr_word;
                    frame_cnt  <= frame_cnt + 1'b1;
                    hold_word  <= data_word;    // goes out next cycle
                    hold_valid <= 1'b1;
                    word_cnt   <= FRAME_CNT_W'(1);
                end else begin
                    o_wr_word <= data_word;
                    word_cnt  <= word_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build the adc fiber testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f verilog.f --top-module tb_adc_fiber_top -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
exit 0

//--- tb/adc_fiber_tests.txt
// columns, all hex: id enable test_src decim adc_a adc_b words ack_stall
// a line with id 0, or the end of the file, ends the run
01 1 0 04 5a3 a5c 12 00
02 1 1 05 000 000 1b 00
03 1 0 00 123 456 c8 00
04 1 0 01 0f0 f0f 3c c8
05 1 1 06 000 000 96 00
06 0 1 04 000 000 00 00
07 1 0 ff 7ff 800 0a 00

//--- tb/tb_adc_fiber_top.sv
////////////////////////////////////////////////////////////
// adc fiber testbench with remote link models, file driven
// mode tests and checks of the transmitted lane words
////////////////////////////////////////////////////////////

module tb_adc_fiber_top;
    import adc_pkg::*;
    import link_pkg::*;

    localparam int MAX_TESTS = 16;
    localparam int FIELDS    = 8;       // words per test line
    localparam int WAIT_MAX  = 2000;    // cycles
    localparam int IDLE_WIN  = 100;     // quiet window that ends a drain

    logic        clk_29_7_1M = 1'b0;
    logic        i_reset;
    sample_t     i_adc_a;
    sample_t     i_adc_b;
    logic        o_tx_req;
    lane_word_t  o_tx_word;
    logic        i_tx_ack;
    logic        i_rx_req;
    lane_word_t  i_rx_word;
    logic        o_rx_ack;
    logic        o_overflow;

    logic [31:0] tests_mem [MAX_TESTS*FIELDS];
    integer      seed;
    int          errors;
    int          n_pass;
    int          n_fail;
    logic        timed_out;

    always #5 clk_29_7_1M = ~clk_29_7_1M;

    adc_fiber_top u_adc_fiber_top (
        .clk_29_7_1M (clk_29_7_1M),
        .i_reset     (i_reset),
        .i_adc_a     (i_adc_a),
        .i_adc_b     (i_adc_b),
        .o_tx_req    (o_tx_req),
        .o_tx_word   (o_tx_word),
        .i_tx_ack    (i_tx_ack),
        .i_rx_req    (i_rx_req),
        .i_rx_word   (i_rx_word),
        .o_rx_ack    (o_rx_ack),
        .o_overflow  (o_overflow)
    );

    task automatic next_cycle();
        @(posedge clk_29_7_1M);
        #1;    // drive and sample just after the edge
    endtask

    task automatic wait_rx_ack(input logic level);
        int n;
        n = 0;
        while (o_rx_ack !== level && n < WAIT_MAX && !timed_out) begin
            next_cycle();
            n++;
        end
        if (o_rx_ack !== level && !timed_out) begin
            $display("timeout waiting for rx ack");
            timed_out = 1'b1;
            errors++;
        end
    endtask

    task automatic wait_tx_req(input logic level, input int limit, output logic seen);
        int n;
        n = 0;
        while (o_tx_req !== level && n < limit) begin
            next_cycle();
            n++;
        end
        seen = (o_tx_req === level);
    endtask

    // remote sender on the control link
    task automatic send_ctrl(input lane_word_t word);
        i_rx_word = word;
        i_rx_req  = 1'b1;
        wait_rx_ack(1'b1);
        i_rx_req = 1'b0;
        wait_rx_ack(1'b0);
        i_rx_word = '0;
    endtask

    // remote receiver on the lane that acks after the stall
    task automatic take_word(input int stall, output lane_word_t word);
        logic seen;
        int   k;
        word = '0;
        wait_tx_req(1'b1, WAIT_MAX, seen);
        if (!seen) begin
            $display("timeout waiting for tx req");
            timed_out = 1'b1;
            errors++;
        end else begin
            word = o_tx_word;
            for (k = 0; k < stall; k++) begin
                next_cycle();
            end
            i_tx_ack = 1'b1;
            wait_tx_req(1'b0, WAIT_MAX, seen);
            if (!seen) begin
                $display("timeout waiting for tx req to fall");
                timed_out = 1'b1;
                errors++;
            end
            i_tx_ack = 1'b0;
        end
    endtask

    task automatic drain_link();
        logic       seen;
        lane_word_t word;
        int         n;
        seen = 1'b1;
        n    = 0;
        while (seen && n < 64 && !timed_out) begin    // fifo plus the word in flight
            wait_tx_req(1'b1, IDLE_WIN, seen);
            if (seen) begin
                take_word(0, word);
            end
            n++;
        end
    endtask

    function automatic lane_word_t mode_word(input logic en, input logic tst,
                                             input logic [DECIM_W-1:0] dec);
        lane_word_t w;
        w                                          = '0;
        w.ctrl.kind                                = KIND_CTRL;
        w.ctrl.opcode                              = OP_SET_MODE;
        w.ctrl.value[MODE_EN_BIT]                  = en;
        w.ctrl.value[MODE_TEST_BIT]                = tst;
        w.ctrl.value[MODE_DECIM_LSB +: DECIM_W]    = dec;
        return w;
    endfunction

    task automatic check_word(input lane_word_t got, input lane_word_t exp);
        if (got !== exp) begin
            errors++;
            if (exp.ctrl.kind == KIND_CTRL) begin
                $display("Mismatch at %0t: got %h, expected header op %0d count %0d",
                         $time, got, exp.ctrl.opcode, exp.ctrl.value);
            end else begin
                $display("Mismatch at %0t: got %h, expected data seq %0d a %h b %h",
                         $time, got, exp.data.seq, exp.data.ch_a, exp.data.ch_b);
            end
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    initial begin
        int               t;
        int               i;
        int               base;
        int               nw;
        int               stall;
        int               errs_before;
        int               seq_n;
        int               frame_n;
        int               in_frame;
        int               last_frame;
        logic [7:0]       dec;
        logic             lossy;
        logic             gap;
        logic             new_frame;
        logic             seen;
        logic [SEQ_W-1:0] last_seq;
        sample_t          ramp;
        lane_word_t       got;
        lane_word_t       exp;
        lane_word_t       other;

        seed      = 90;
        timed_out = 1'b0;
        errors    = 0;
        n_pass    = 0;
        n_fail    = 0;
        i_reset   = 1'b1;
        i_adc_a   = '0;
        i_adc_b   = '0;
        i_tx_ack  = 1'b0;
        i_rx_req  = 1'b0;
        i_rx_word = '0;
        for (t = 0; t < MAX_TESTS*FIELDS; t++) begin
            tests_mem[t] = '0;
        end
        $readmemh("tb/adc_fiber_tests.txt", tests_mem);
        for (i = 0; i < 16; i++) begin
            next_cycle();
        end
        i_reset = 1'b0;

        for (t = 0; t < MAX_TESTS && tests_mem[t*FIELDS] != 0 && !timed_out; t++) begin
            base        = t * FIELDS;
            dec         = tests_mem[base+3][7:0];
            nw          = int'(tests_mem[base+6]);
            stall       = int'(tests_mem[base+7]);
            errs_before = errors;

            // stop the old stream and empty the lane
            send_ctrl(mode_word(1'b0, 1'b0, 8'd1));
            check_flag(o_overflow, 1'b0, "o_overflow after mode change");
            drain_link();

            i_adc_a = tests_mem[base+4][SAMPLE_W-1:0];
            i_adc_b = tests_mem[base+5][SAMPLE_W-1:0];
            send_ctrl(mode_word(tests_mem[base+1][0], tests_mem[base+2][0], dec));

            // link needs 3 to 4 cycles per word so decim below 4 overruns
            lossy      = (stall != 0) || (dec < 8'd4);
            seq_n      = 0;
            frame_n    = 0;
            in_frame   = FRAME_LEN;    // header leads the stream
            last_frame = -1;
            last_seq   = '0;
            new_frame  = 1'b1;
            gap        = 1'b0;

            for (i = 0; i < nw && !timed_out; i++) begin
                take_word((i == 0) ? stall : int'($unsigned($random(seed)) % 32'd2), got);
                exp = '0;
                if (!timed_out) begin
                    if (lossy && got.ctrl.kind == KIND_CTRL) begin
                        exp.ctrl.kind   = KIND_CTRL;
                        exp.ctrl.opcode = OP_FRAME_HDR;
                        exp.ctrl.value  = (int'(got.ctrl.value) > last_frame) ?
                                          got.ctrl.value : VALUE_W'(last_frame + 1);
                        if (int'(got.ctrl.value) > last_frame + 1) begin
                            gap = 1'b1;    // whole frames lost
                        end
                        last_frame = int'(got.ctrl.value);
                        new_frame  = 1'b1;
                    end else if (lossy) begin
                        exp.data.seq  = (new_frame || got.data.seq != last_seq) ?
                                        got.data.seq : last_seq + 1'b1;
                        exp.data.ch_a = i_adc_a;
                        exp.data.ch_b = i_adc_b;
                        if (!new_frame && SEQ_W'(got.data.seq - last_seq) > SEQ_W'(1)) begin
                            gap = 1'b1;
                        end
                        last_seq  = got.data.seq;
                        new_frame = 1'b0;
                    end else if (in_frame == FRAME_LEN) begin
                        exp.ctrl.kind   = KIND_CTRL;
                        exp.ctrl.opcode = OP_FRAME_HDR;
                        exp.ctrl.value  = VALUE_W'(frame_n);
                        frame_n++;
                        in_frame = 0;
                    end else begin
                        ramp          = sample_t'(seq_n * int'(RAMP_STEP));
                        exp.data.seq  = SEQ_W'(seq_n);    // wraps at 128
                        exp.data.ch_a = tests_mem[base+2][0] ? ramp : i_adc_a;
                        exp.data.ch_b = tests_mem[base+2][0] ? ~ramp : i_adc_b;
                        seq_n++;
                        in_frame++;
                    end
                    check_word(got, exp);
                    if (i == 0) begin
                        // words the receiver acks but must not act on
                        other          = '0;
                        other.data.seq = OP_SET_MODE;    // data kind with SET_MODE bits
                        send_ctrl(other);
                        other             = '0;
                        other.ctrl.kind   = KIND_CTRL;
                        other.ctrl.opcode = 7'h55;
                        other.ctrl.value  = '1;
                        send_ctrl(other);
                    end
                end
            end

            if (nw == 0 && !timed_out) begin
                wait_tx_req(1'b1, IDLE_WIN, seen);
                check_flag(seen, 1'b0, "tx req while disabled");
                check_flag(o_rx_ack, 1'b0, "o_rx_ack while idle");
            end else if (!timed_out) begin
                check_flag(o_overflow, lossy, "o_overflow");
                if (lossy) begin
                    check_flag(gap, 1'b1, "seq gap");
                end
            end

            if (errors == errs_before) begin
                n_pass++;
                $display("test %0d ok", tests_mem[base]);
            end else begin
                n_fail++;
                $display("test %0d failed", tests_mem[base]);
            end
        end

        $display("summary: %0d passed, %0d failed", n_pass, n_fail);
        if (errors == 0 && !timed_out && n_pass > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- verilog.f
logic/adc_pkg.sv
logic/link_pkg.sv
logic/adc_capture.sv
logic/sample_packer.sv
logic/lane_fifo.sv
logic/lane_tx.sv
logic/ctrl_rx.sv
logic/adc_fiber_top.sv
tb/tb_adc_fiber_top.sv
